// ==== common/mspi_pkg.sv ====
// Buffer geometry, SPI word types and command word field positions
// Host start handshake state encoding
package mspi_pkg;

    // Buffer geometry
    localparam int buf_size    = 256;
    localparam int buf_adwidth = $clog2(buf_size);

    // SPI side sizes
    localparam int ss_width = 4;
    localparam int word_w   = 32;

    typedef logic [word_w-1:0]           spi_word_t;
    typedef logic [buf_adwidth-1:0]      buf_addr_t;
    typedef logic [$clog2(ss_width)-1:0] cs_sel_t;
    typedef logic [ss_width-1:0]         ss_vec_t;
    typedef logic [$clog2(word_w)-1:0]   bit_cnt_t;

    ////////////////////////////////////////
    // Command word layout
    ////////////////////////////////////////

    // Start level
    localparam int cmd_start_bit = 0;
    // Last word index, buf_adwidth bits wide
    localparam int cmd_len_lsb   = 2;
    // Chip select index in the top bits
    localparam int cmd_cs_lsb    = 30;

    // Host side start handshake
    typedef enum logic [1:0] {
        cdc_idle_lo,
        cdc_wait_hi,
        cdc_idle_hi,
        cdc_wait_lo
    } cdc_state_t;

endpackage

// ==== mspi_intf/mspi_cmd_decode.sv ====
// Host start handshake FSM and its clock crossing into sclk
// Start edge detect and command field latch in sclk
`timescale 1ns/1ps

module mspi_cmd_decode (
    input  logic                avmm_clk,
    input  logic                rst_n_avmm,
    input  mspi_pkg::spi_word_t cmd_reg,
    input  logic                sclk,
    input  logic                rst_n_sclk,
    output logic                start_pulse,
    output mspi_pkg::buf_addr_t last_wd,
    output mspi_pkg::cs_sel_t   cs_sel
);

    import mspi_pkg::*;

    cdc_state_t cdc_state;
    logic       cdc_req;
    logic       cdc_req_sclk;
    logic       cdc_ack;
    logic       start_lvl;
    logic       start_sync;
    logic       start_d1;

    ////////////////////////////////////////
    // Host side handshake
    ////////////////////////////////////////

    // Each start level is held through a full req/ack round trip so a
    // slow sclk still sees both the high and the low phase
    always_ff @(posedge avmm_clk or negedge rst_n_avmm) begin
        if (!rst_n_avmm) begin
            cdc_state <= cdc_idle_lo;
            cdc_req   <= 1'b0;
            start_lvl <= 1'b0;
        end else begin
            case (cdc_state)
                cdc_idle_lo: if (cmd_reg[cmd_start_bit] && !cdc_ack) begin
                    cdc_state <= cdc_wait_hi;
                    cdc_req   <= 1'b1;
                end
                cdc_wait_hi: if (cdc_ack) begin
                    cdc_state <= cdc_idle_hi;
                    cdc_req   <= 1'b0;
                    start_lvl <= 1'b1;
                end
                cdc_idle_hi: if (!cmd_reg[cmd_start_bit] && !cdc_ack) begin
                    cdc_state <= cdc_wait_lo;
                    cdc_req   <= 1'b1;
                end
                cdc_wait_lo: if (cdc_ack) begin
                    cdc_state <= cdc_idle_lo;
                    cdc_req   <= 1'b0;
                    start_lvl <= 1'b0;
                end
                default: cdc_state <= cdc_idle_lo;
            endcase
        end
    end

    // Request into sclk, then back out as the acknowledge
    spi_bitsync u_sync_req (
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .data_in    (cdc_req),
        .data_out   (cdc_req_sclk)
    );

    spi_bitsync u_sync_ack (
        .sclk       (avmm_clk),
        .rst_n_sclk (rst_n_avmm),
        .data_in    (cdc_req_sclk),
        .data_out   (cdc_ack)
    );

    ////////////////////////////////////////
    // SPI side start and command
    ////////////////////////////////////////

    spi_bitsync u_sync_start (
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .data_in    (start_lvl),
        .data_out   (start_sync)
    );

    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            start_d1 <= 1'b0;
        end else begin
            start_d1 <= start_sync;
        end
    end

    // Rising edge only, so a held start bit does not retrigger
    assign start_pulse = start_sync & ~start_d1;

    // Host keeps cmd_reg stable, so it is safe to sample here
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            last_wd <= '0;
            cs_sel  <= '0;
        end else if (start_pulse) begin
            last_wd <= cmd_reg[cmd_len_lsb +: buf_adwidth];
            cs_sel  <= cmd_reg[cmd_cs_lsb +: $bits(cs_sel_t)];
        end
    end

endmodule

// ==== mspi_intf/mspi_rx_result.sv ====
// MISO word assembly and receive buffer write port
`timescale 1ns/1ps

module mspi_rx_result (
    input  logic                sclk,
    input  logic                rst_n_sclk,
    input  logic                miso,
    input  logic                sel_active,
    input  logic                word_done,
    input  mspi_pkg::buf_addr_t word_idx,
    output logic                rx_we,
    output mspi_pkg::buf_addr_t rx_waddr,
    output mspi_pkg::spi_word_t rx_wdata
);

    import mspi_pkg::*;

    // Sampled on the rising edge, MSB arrives first
    always_ff @(posedge sclk) begin
        if (sel_active) begin
            rx_wdata <= {rx_wdata[word_w-2:0], miso};
        end
    end

    // Write lands one cycle after the last bit is in
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            rx_we <= 1'b0;
        end else begin
            rx_we <= word_done;
        end
    end

    always_ff @(posedge sclk) begin
        if (word_done) begin
            rx_waddr <= word_idx;
        end
    end

endmodule

// ==== mspi_intf/mspi_shift_exec.sv ====
// Word and bit counter, transmit buffer read addressing
// MOSI shift register, chip select decode and activity flag
`timescale 1ns/1ps

module mspi_shift_exec (
    input  logic                sclk,
    input  logic                rst_n_sclk,
    input  logic                start_pulse,
    input  mspi_pkg::buf_addr_t last_wd,
    input  mspi_pkg::cs_sel_t   cs_sel,
    output mspi_pkg::buf_addr_t tx_rd_addr,
    input  mspi_pkg::spi_word_t tx_rd_data,
    output logic                mosi,
    output mspi_pkg::ss_vec_t   ss_n,
    output logic                spi_active,
    output logic                word_done,
    output mspi_pkg::buf_addr_t word_idx,
    output logic                sel_active
);

    import mspi_pkg::*;

    logic      trans_en;
    logic      trans_en_d;
    buf_addr_t wd_cnt;
    bit_cnt_t  bit_cnt;
    logic      last_bit;
    spi_word_t tx_shift;

    assign last_bit   = &bit_cnt;
    assign spi_active = trans_en | trans_en_d;

    // Handed to the result block
    assign word_done  = trans_en & last_bit;
    assign word_idx   = wd_cnt;
    assign sel_active = ~&ss_n;

    ////////////////////////////////////////
    // Transfer control
    ////////////////////////////////////////

    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            trans_en   <= 1'b0;
            trans_en_d <= 1'b0;
            wd_cnt     <= '0;
            bit_cnt    <= '0;
            tx_rd_addr <= '0;
        end else begin
            if (start_pulse) begin
                trans_en <= 1'b1;
            end else if (trans_en && last_bit && wd_cnt == last_wd) begin
                trans_en <= 1'b0;
            end
            trans_en_d <= trans_en;

            // Word index sits above the bit index in one counter
            if (trans_en) begin
                {wd_cnt, bit_cnt} <= {wd_cnt, bit_cnt} + 1'b1;
            end else begin
                {wd_cnt, bit_cnt} <= '0;
            end

            // Address runs one word ahead of the shifter
            if (start_pulse || (trans_en && last_bit)) begin
                tx_rd_addr <= tx_rd_addr + 1'b1;
            end else if (!spi_active) begin
                tx_rd_addr <= '0;
            end
        end
    end

    // Word 0 is already on tx_rd_data while idle
    always_ff @(posedge sclk) begin
        if (start_pulse || (trans_en && last_bit)) begin
            tx_shift <= tx_rd_data;
        end else begin
            tx_shift <= {tx_shift[word_w-2:0], 1'b0};
        end
    end

    ////////////////////////////////////////
    // Pin drivers on the falling edge
    ////////////////////////////////////////

    always_ff @(negedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            mosi <= 1'b0;
            ss_n <= '1;
        end else begin
            mosi <= trans_en ? tx_shift[word_w-1] : 1'b0;
            // One-hot low at cs_sel while transferring
            ss_n <= ~(ss_vec_t'(trans_en) << cs_sel);
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the SPI master testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mspi_tb \
    -f sources.f -Mdir obj_dir -o mspi_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/mspi_sim > sim.log 2>&1 || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// ==== source/mspi_buffer.sv ====
// Dual-clock word buffer
// Synchronous write port, registered read port in a second clock
`timescale 1ns/1ps

module mspi_buffer (
    input  logic               wr_clk,
    input  logic               wr_en,
    input  mspi_pkg::buf_addr_t wr_addr,
    input  mspi_pkg::spi_word_t wr_data,
    input  logic               rd_clk,
    input  mspi_pkg::buf_addr_t rd_addr,
    output mspi_pkg::spi_word_t rd_data
);

    import mspi_pkg::*;

    spi_word_t mem [buf_size];

    // Write side
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read side, data one rd_clk cycle after the address
    always_ff @(posedge rd_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== source/mspi_top.sv ====
// SPI master top level
// Command decode, shift execute, receive result and the two word buffers
`timescale 1ns/1ps

module mspi_top (
    input  logic                avmm_clk,
    input  logic                rst_n_avmm,
    input  logic                sclk,
    input  logic                rst_n_sclk,
    input  mspi_pkg::spi_word_t cmd_reg,
    input  logic                tx_wr_en,
    input  mspi_pkg::buf_addr_t tx_wr_addr,
    input  mspi_pkg::spi_word_t tx_wr_data,
    input  mspi_pkg::buf_addr_t rx_rd_addr,
    output mspi_pkg::spi_word_t rx_rd_data,
    output logic                spi_active,
    output mspi_pkg::ss_vec_t   ss_n,
    output logic                mosi,
    input  logic                miso
);

    import mspi_pkg::*;

    logic      start_pulse;
    buf_addr_t last_wd;
    cs_sel_t   cs_sel;
    buf_addr_t tx_rd_addr;
    spi_word_t tx_rd_data;
    logic      word_done;
    buf_addr_t word_idx;
    logic      sel_active;
    logic      rx_we;
    buf_addr_t rx_waddr;
    spi_word_t rx_wdata;

    mspi_cmd_decode u_cmd_decode (
        .avmm_clk    (avmm_clk),
        .rst_n_avmm  (rst_n_avmm),
        .cmd_reg     (cmd_reg),
        .sclk        (sclk),
        .rst_n_sclk  (rst_n_sclk),
        .start_pulse (start_pulse),
        .last_wd     (last_wd),
        .cs_sel      (cs_sel)
    );

    mspi_shift_exec u_shift_exec (
        .sclk        (sclk),
        .rst_n_sclk  (rst_n_sclk),
        .start_pulse (start_pulse),
        .last_wd     (last_wd),
        .cs_sel      (cs_sel),
        .tx_rd_addr  (tx_rd_addr),
        .tx_rd_data  (tx_rd_data),
        .mosi        (mosi),
        .ss_n        (ss_n),
        .spi_active  (spi_active),
        .word_done   (word_done),
        .word_idx    (word_idx),
        .sel_active  (sel_active)
    );

    mspi_rx_result u_rx_result (
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .miso       (miso),
        .sel_active (sel_active),
        .word_done  (word_done),
        .word_idx   (word_idx),
        .rx_we      (rx_we),
        .rx_waddr   (rx_waddr),
        .rx_wdata   (rx_wdata)
    );

    // Host writes, SPI side reads
    mspi_buffer u_tx_buf (
        .wr_clk  (avmm_clk),
        .wr_en   (tx_wr_en),
        .wr_addr (tx_wr_addr),
        .wr_data (tx_wr_data),
        .rd_clk  (sclk),
        .rd_addr (tx_rd_addr),
        .rd_data (tx_rd_data)
    );

    // SPI side writes, host reads
    mspi_buffer u_rx_buf (
        .wr_clk  (sclk),
        .wr_en   (rx_we),
        .wr_addr (rx_waddr),
        .wr_data (rx_wdata),
        .rd_clk  (avmm_clk),
        .rd_addr (rx_rd_addr),
        .rd_data (rx_rd_data)
    );

endmodule

// ==== source/spi_bitsync.sv ====
// Two-flop level synchronizer into a destination clock
`timescale 1ns/1ps

module spi_bitsync (
    input  logic sclk,
    input  logic rst_n_sclk,
    input  logic data_in,
    output logic data_out
);

    logic meta;

    // First stage may go metastable, second stage settles it
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            meta     <= 1'b0;
            data_out <= 1'b0;
        end else begin
            meta     <= data_in;
            data_out <= meta;
        end
    end

endmodule

// ==== sources.f ====
common/mspi_pkg.sv
source/spi_bitsync.sv
source/mspi_buffer.sv
mspi_intf/mspi_cmd_decode.sv
mspi_intf/mspi_shift_exec.sv
mspi_intf/mspi_rx_result.sv
source/mspi_top.sv
verif/mspi_clk_gen.sv
verif/mspi_tb.sv

// ==== verif/mspi_clk_gen.sv ====
// Testbench clock source with a settable period
// Active-low reset held for the first few cycles
`timescale 1ns/1ps

module mspi_clk_gen #(
    parameter real period_ns  = 8.0,
    parameter int  rst_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0);
            clk = ~clk;
        end
    end

    // Release just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== verif/mspi_tb.sv ====
// Testbench for the SPI master top level
// SPI slave model, mosi and chip select recorder, reference checks
// Tests for reset, single word, random bursts, receive path, start edge
`timescale 1ns/1ps

module mspi_tb;

    import mspi_pkg::*;

    localparam real sclk_period_ns = 8.0;
    localparam real avmm_period_ns = 10.0;
    localparam int  wait_limit     = 400;

    logic      sclk;
    logic      rst_n_sclk;
    logic      avmm_clk;
    logic      rst_n_avmm;
    spi_word_t cmd_reg;
    logic      tx_wr_en;
    buf_addr_t tx_wr_addr;
    spi_word_t tx_wr_data;
    buf_addr_t rx_rd_addr;
    spi_word_t rx_rd_data;
    logic      spi_active;
    ss_vec_t   ss_n;
    logic      mosi;
    logic      miso;

    integer    seed = 32'h6bb5;
    int        errors;
    int        checks;
    int        test_errors;
    spi_word_t tx_words [buf_size];
    logic      mosi_q [$];
    logic      miso_q [$];
    int        ss_low_cnt [ss_width];
    int        active_cnt;

    mspi_clk_gen #(.period_ns(sclk_period_ns)) u_sclk_gen (
        .clk   (sclk),
        .rst_n (rst_n_sclk)
    );

    mspi_clk_gen #(.period_ns(avmm_period_ns)) u_avmm_gen (
        .clk   (avmm_clk),
        .rst_n (rst_n_avmm)
    );

    mspi_top u_mspi_top (
        .avmm_clk   (avmm_clk),
        .rst_n_avmm (rst_n_avmm),
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .cmd_reg    (cmd_reg),
        .tx_wr_en   (tx_wr_en),
        .tx_wr_addr (tx_wr_addr),
        .tx_wr_data (tx_wr_data),
        .rx_rd_addr (rx_rd_addr),
        .rx_rd_data (rx_rd_data),
        .spi_active (spi_active),
        .ss_n       (ss_n),
        .mosi       (mosi),
        .miso       (miso)
    );

    ////////////////////////////////////////
    // SPI slave model
    ////////////////////////////////////////

    // New miso bit just after each falling edge while selected
    always begin
        @(negedge sclk);
        #1;
        if (ss_n !== '1) begin
            miso = 1'($random(seed));
        end
    end

    // Record both data lines on every selected rising edge
    always @(posedge sclk) begin
        if (ss_n !== '1) begin
            mosi_q.push_back(mosi);
            miso_q.push_back(miso);
            for (int i = 0; i < ss_width; i++) begin
                if (!ss_n[i]) begin
                    ss_low_cnt[i]++;
                end
            end
        end
    end

    // Length of the busy window in sclk cycles
    always @(negedge sclk) begin
        if (spi_active === 1'b1) begin
            active_cnt++;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic clear_records();
        mosi_q.delete();
        miso_q.delete();
        for (int i = 0; i < ss_width; i++) begin
            ss_low_cnt[i] = 0;
        end
        active_cnt = 0;
    endtask

    task automatic load_tx_words(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge avmm_clk);
            #1;
            tx_words[i] = $random(seed);
            tx_wr_en    = 1'b1;
            tx_wr_addr  = buf_addr_t'(i);
            tx_wr_data  = tx_words[i];
        end
        @(posedge avmm_clk);
        #1;
        tx_wr_en = 1'b0;
    endtask

    task automatic launch(input int last, input int cs);
        spi_word_t cmd;
        cmd = '0;
        cmd[cmd_len_lsb +: buf_adwidth]     = buf_addr_t'(last);
        cmd[cmd_cs_lsb +: $bits(cs_sel_t)] = cs_sel_t'(cs);
        cmd[cmd_start_bit]                  = 1'b1;
        @(posedge avmm_clk);
        #1;
        cmd_reg = cmd;
    endtask

    task automatic wait_active(input logic level, input int limit);
        int cnt;
        cnt = 0;
        while (spi_active !== level && cnt < limit) begin
            @(posedge sclk);
            #1;
            cnt++;
        end
        if (spi_active !== level) begin
            $display("Timed out waiting for spi_active to become %0d", level);
            errors++;
        end
    endtask

    // Start level back to low through the full host handshake
    task automatic drop_start();
        int cnt;
        @(posedge avmm_clk);
        #1;
        cmd_reg[cmd_start_bit] = 1'b0;
        cnt = 0;
        while (u_mspi_top.u_cmd_decode.cdc_state != cdc_idle_lo && cnt < wait_limit) begin
            @(posedge avmm_clk);
            #1;
            cnt++;
        end
        if (u_mspi_top.u_cmd_decode.cdc_state != cdc_idle_lo) begin
            $display("Timed out waiting for the start handshake to return low");
            errors++;
        end
    endtask

    task automatic run_burst(input int last, input int cs);
        clear_records();
        load_tx_words(last + 1);
        launch(last, cs);
        wait_active(1'b1, 64);
        wait_active(1'b0, word_w * (last + 1) + 16);
    endtask

    task automatic check_burst(input int last, input int cs);
        int        nbits;
        spi_word_t got;
        nbits = word_w * (last + 1);
        check_value("mosi bit count", nbits, mosi_q.size());
        if (mosi_q.size() == nbits) begin
            for (int w = 0; w <= last; w++) begin
                got = '0;
                for (int b = 0; b < word_w; b++) begin
                    got = {got[word_w-2:0], mosi_q[w*word_w+b]};
                end
                check_value($sformatf("mosi word %0d", w), tx_words[w], got);
            end
        end
        for (int i = 0; i < ss_width; i++) begin
            check_value($sformatf("ss_n[%0d] low edges", i), (i == cs) ? nbits : 0,
                        ss_low_cnt[i]);
        end
        // All transfer cycles plus one trailing cycle
        check_value("spi_active cycles", nbits + 1, active_cnt);
    endtask

    // Receive words rebuilt from the recorded miso stream with the MSB first
    task automatic check_rx(input int last);
        spi_word_t exp;
        check_value("miso bit count", word_w * (last + 1), miso_q.size());
        for (int w = 0; w <= last && miso_q.size() >= word_w * (last + 1); w++) begin
            exp = '0;
            for (int b = 0; b < word_w; b++) begin
                exp = {exp[word_w-2:0], miso_q[w*word_w+b]};
            end
            @(posedge avmm_clk);
            #1;
            rx_rd_addr = buf_addr_t'(w);
            @(posedge avmm_clk);
            #1;
            check_value($sformatf("rx_rd_data[%0d]", w), exp, rx_rd_data);
        end
    endtask

    task automatic watch_idle(input int cycles);
        int high_cnt;
        high_cnt = 0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge sclk);
            #1;
            if (spi_active !== 1'b0) begin
                high_cnt++;
            end
        end
        check_value("spi_active high cycles", 0, high_cnt);
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %s, %0d errors", num, name,
                 (errors == test_errors) ? "ok" : "failed", errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int last;
        int cs;
        int cnt;
        cmd_reg     = '0;
        tx_wr_en    = 1'b0;
        tx_wr_addr  = '0;
        tx_wr_data  = '0;
        rx_rd_addr  = '0;
        miso        = 1'b0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        clear_records();

        // Outputs while reset is still low
        @(posedge sclk);
        @(negedge sclk);
        #1;
        check_value("ss_n", 4'hf, ss_n);
        check_value("mosi", 0, mosi);
        check_value("spi_active", 0, spi_active);
        cnt = 0;
        while ((rst_n_sclk !== 1'b1 || rst_n_avmm !== 1'b1) && cnt < 100) begin
            @(posedge avmm_clk);
            #1;
            cnt++;
        end
        if (rst_n_sclk !== 1'b1 || rst_n_avmm !== 1'b1) begin
            $display("Timed out waiting for reset release");
            errors++;
        end
        @(negedge sclk);
        #1;
        check_value("ss_n", 4'hf, ss_n);
        check_value("mosi", 0, mosi);
        check_value("spi_active", 0, spi_active);
        end_test(1, "reset state");

        run_burst(0, 0);
        check_burst(0, 0);
        drop_start();
        end_test(2, "single word to cs 0");

        // Last burst keeps its start bit high for the next tests
        for (int n = 0; n < 4; n++) begin
            last = $random(seed) & 32'h3;
            cs   = $random(seed) & 32'h3;
            run_burst(last, cs);
            check_burst(last, cs);
            if (n < 3) begin
                drop_start();
            end
        end
        end_test(3, "random bursts");

        check_rx(last);
        end_test(4, "receive path");

        watch_idle(200);
        drop_start();
        last = $random(seed) & 32'h3;
        cs   = $random(seed) & 32'h3;
        run_burst(last, cs);
        check_burst(last, cs);
        check_rx(last);
        watch_idle(200);
        end_test(5, "start is edge triggered");

        $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
